// ==== sched_cfg_pkg.sv ====
`default_nettype none

package sched_cfg_pkg;

  // ethernet receive ports and cores behind the fabric
  localparam int if_count   = 2;
  localparam int core_count = 4;
  localparam int slot_count = 4;

  // stream widths
  localparam int data_width = 64;
  localparam int keep_width = 8;
  localparam int ctrl_width = 64;

  // slot numbers start at 1, so 1..slot_count must fit
  localparam int slot_width = 3;

  localparam int core_id_width    = 2;
  localparam int port_width       = 1;
  localparam int id_slot_width    = core_id_width + slot_width;
  localparam int fifo_depth_width = $clog2(slot_count + 1);

  localparam int loopback_depth = 16;

endpackage

`default_nettype wire

// ==== sched_msg_pkg.sv ====
`default_nettype none

package sched_msg_pkg;
  import sched_cfg_pkg::*;

  // length field at the bottom of a slot return word
  localparam int len_width = 16;

  // word sent to every core once after reset
  localparam logic [ctrl_width-1:0] core_reset_word = {{(ctrl_width - 1){1'b1}}, 1'b0};

  typedef enum logic [3:0] {
    slot_return = 4'd0,
    loopback    = 4'd1,
    slot_load   = 4'd3
  } msg_type_e;

  typedef struct packed {
    msg_type_e                                     msg_type;
    logic [ctrl_width-4-slot_width-len_width-1:0] pad;
    logic [slot_width-1:0]                         slot;
    logic [len_width-1:0]                          length;
  } slot_return_t;

  typedef struct packed {
    msg_type_e                        msg_type;
    logic [ctrl_width-4-slot_width-1:0] pad;
    logic [slot_width-1:0]            count;
  } slot_load_t;

  typedef struct packed {
    msg_type_e             msg_type;
    logic [ctrl_width-5:0] payload;
  } loopback_t;

  // one control word, read according to its type nibble
  typedef union packed {
    slot_return_t slot_return;
    slot_load_t   slot_load;
    loopback_t    loopback;
  } ctrl_word_u;

  typedef struct packed {
    logic [core_id_width-1:0] core;
    logic [slot_width-1:0]    slot;
  } id_slot_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [keep_width-1:0] keep;
    logic                  last;
  } rx_beat_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [keep_width-1:0] keep;
    logic                  last;
    id_slot_t              dest;
    logic [port_width-1:0] user;
  } fwd_beat_t;

  typedef struct packed {
    ctrl_word_u               data;
    logic [core_id_width-1:0] user;
  } ctrl_in_t;

  typedef struct packed {
    ctrl_word_u               data;
    logic [core_id_width-1:0] dest;
  } ctrl_out_t;

endpackage

`default_nettype wire

// ==== slot_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module slot_fifo #(
  parameter int width = 3,
  parameter int depth = 4
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         clear,
  input  wire                         din_valid,
  input  wire  [width-1:0]            din,
  output logic                        din_ready,
  output logic                        dout_valid,
  output logic [width-1:0]            dout,
  input  wire                         dout_ready,
  output logic [$clog2(depth+1)-1:0]  count
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

  logic [width-1:0]     mem [depth];
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width-1:0] wr_ptr;
  logic                 push;
  logic                 pop;

  function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign din_ready  = (count != ($clog2(depth+1))'(depth));
  assign dout_valid = (count != '0);
  assign dout       = mem[rd_ptr];

  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (push && !clear) begin
      mem[wr_ptr] <= din;
    end
  end

  // clear wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== ctrl_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_ingress (
  input  wire                                   clk,
  input  wire                                   rst,
  input  wire sched_msg_pkg::ctrl_in_t          ctrl_in,
  input  wire                                   ctrl_in_valid,
  output logic                                  ctrl_in_ready,
  output logic [sched_cfg_pkg::core_count-1:0]  slot_wr,
  output logic [sched_cfg_pkg::slot_width-1:0]  slot_wr_data,
  output logic [sched_cfg_pkg::core_count-1:0]  slot_clear,
  input  wire  [sched_cfg_pkg::core_count-1:0]  slot_room,
  output logic                                  lb_wr,
  output sched_msg_pkg::ctrl_out_t              lb_data,
  input  wire                                   lb_room
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  ctrl_word_u               word;
  msg_type_e                mt;
  logic [core_id_width-1:0] src;

  // loader state
  logic                     ld_clear;
  logic [slot_width-1:0]    ld_remaining;
  logic [slot_width-1:0]    ld_next;
  logic [core_id_width-1:0] ld_core;

  logic                  ld_busy;
  logic                  ld_writing;
  logic                  ld_accept;
  logic [slot_width-1:0] ld_count;
  logic                  ret_ok;
  logic                  ret_wr;

  assign word = ctrl_in.data;
  assign src  = ctrl_in.user;
  assign mt   = word.slot_return.msg_type;

  assign ld_busy    = ld_clear || (ld_remaining != '0);
  assign ld_writing = !ld_clear && (ld_remaining != '0);

  // the shared write slot belongs to the loader while it writes
  assign ret_ok = slot_room[src] && !ld_writing && !(ld_busy && (ld_core == src));

  always_comb begin
    case (mt)
      slot_return: ctrl_in_ready = ret_ok;
      loopback:    ctrl_in_ready = lb_room;
      slot_load:   ctrl_in_ready = !ld_busy;
      // unknown types are swallowed
      default:     ctrl_in_ready = 1'b1;
    endcase
  end

  assign ret_wr    = ctrl_in_valid && (mt == slot_return) && ret_ok;
  assign ld_accept = ctrl_in_valid && (mt == slot_load) && !ld_busy;

  // never load more slots than a FIFO holds
  assign ld_count = (word.slot_load.count > slot_width'(slot_count)) ?
                    slot_width'(slot_count) : word.slot_load.count;

  always_comb begin
    slot_wr    = '0;
    slot_clear = '0;
    if (ld_writing) begin
      slot_wr[ld_core] = 1'b1;
    end
    if (ret_wr) begin
      slot_wr[src] = 1'b1;
    end
    if (ld_clear) begin
      slot_clear[ld_core] = 1'b1;
    end
  end

  assign slot_wr_data = ld_writing ? ld_next : word.slot_return.slot;

  always_comb begin
    lb_wr        = ctrl_in_valid && (mt == loopback) && lb_room;
    lb_data.data = word;
    lb_data.dest = src;
  end

  // clear cycle first, then one slot per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      ld_clear     <= 1'b0;
      ld_remaining <= '0;
    end else if (ld_accept) begin
      ld_clear     <= 1'b1;
      ld_remaining <= ld_count;
    end else if (ld_clear) begin
      ld_clear <= 1'b0;
    end else if (ld_remaining != '0) begin
      ld_remaining <= ld_remaining - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_accept) begin
      ld_core <= src;
      ld_next <= slot_width'(1);
    end else if (ld_writing) begin
      ld_next <= ld_next + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== core_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_select (
  input  wire  [sched_cfg_pkg::core_count-1:0][sched_cfg_pkg::fifo_depth_width-1:0] counts,
  output logic [sched_cfg_pkg::core_id_width-1:0] best_core,
  output logic                                    any_slot
);
  import sched_cfg_pkg::*;

  localparam int levels = $clog2(core_count);

  logic [fifo_depth_width-1:0] val [levels+1][core_count];
  logic [core_id_width-1:0]    idx [levels+1][core_count];

  always_comb begin
    for (int l = 0; l <= levels; l++) begin
      for (int n = 0; n < core_count; n++) begin
        val[l][n] = '0;
        idx[l][n] = '0;
      end
    end
    for (int n = 0; n < core_count; n++) begin
      val[0][n] = counts[n];
      idx[0][n] = core_id_width'(n);
    end
    // upper node must be strictly larger, so ties keep the lower index
    for (int l = 0; l < levels; l++) begin
      for (int n = 0; n < (core_count >> (l + 1)); n++) begin
        if (val[l][2*n+1] > val[l][2*n]) begin
          val[l+1][n] = val[l][2*n+1];
          idx[l+1][n] = idx[l][2*n+1];
        end else begin
          val[l+1][n] = val[l][2*n];
          idx[l+1][n] = idx[l][2*n];
        end
      end
    end
  end

  assign best_core = idx[levels][0];
  assign any_slot  = |counts;

endmodule

`default_nettype wire

// ==== port_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_dispatch (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire sched_msg_pkg::rx_beat_t [sched_cfg_pkg::if_count-1:0] rx,
  input  wire  [sched_cfg_pkg::if_count-1:0]     rx_valid,
  output logic [sched_cfg_pkg::if_count-1:0]     rx_ready,
  output sched_msg_pkg::fwd_beat_t [sched_cfg_pkg::if_count-1:0] fwd,
  output logic [sched_cfg_pkg::if_count-1:0]     fwd_valid,
  input  wire  [sched_cfg_pkg::if_count-1:0]     fwd_ready,
  input  wire  [sched_cfg_pkg::core_id_width-1:0] best_core,
  input  wire                                    any_slot,
  input  wire  [sched_cfg_pkg::core_count-1:0][sched_cfg_pkg::slot_width-1:0] head_slots,
  output logic [sched_cfg_pkg::core_count-1:0]   slot_pop
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  id_slot_t                 dest_q [if_count];
  logic [if_count-1:0]      dest_valid;
  logic [port_width-1:0]    rr_ptr;

  logic [if_count-1:0]      last_xfer;
  logic [if_count-1:0]      req;
  logic                     grant_valid;
  logic [port_width-1:0]    grant_idx;
  logic [id_slot_width-1:0] next_desc;

  assign last_xfer = rx_valid & rx_ready;
  // a port without a destination, or finishing its packet, asks for one
  always_comb begin
    for (int p = 0; p < if_count; p++) begin
      req[p] = !dest_valid[p] || (last_xfer[p] && rx[p].last);
    end
  end

  // round robin search starting at rr_ptr
  always_comb begin
    int cand;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int k = if_count - 1; k >= 0; k--) begin
      cand = (int'(rr_ptr) + k) % if_count;
      if (req[cand] && any_slot) begin
        grant_valid = 1'b1;
        grant_idx   = port_width'(cand);
      end
    end
  end

  assign next_desc = {best_core, head_slots[best_core]};

  always_comb begin
    slot_pop = '0;
    slot_pop[best_core] = grant_valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_valid <= '0;
      rr_ptr     <= '0;
    end else begin
      for (int p = 0; p < if_count; p++) begin
        if (last_xfer[p] && rx[p].last) begin
          dest_valid[p] <= 1'b0;
        end
      end
      if (grant_valid) begin
        dest_valid[grant_idx] <= 1'b1;
        rr_ptr <= port_width'((int'(grant_idx) + 1) % if_count);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_valid) begin
      dest_q[grant_idx] <= id_slot_t'(next_desc);
    end
  end

  // beats pass straight through, stamped with destination and port
  always_comb begin
    for (int p = 0; p < if_count; p++) begin
      fwd[p].data = rx[p].data;
      fwd[p].keep = rx[p].keep;
      fwd[p].last = rx[p].last;
      fwd[p].dest = dest_q[p];
      fwd[p].user = port_width'(p);
    end
  end

  assign fwd_valid = rx_valid & dest_valid;
  assign rx_ready  = fwd_ready & dest_valid;

endmodule

`default_nettype wire

// ==== ctrl_egress.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_egress (
  input  wire                               clk,
  input  wire                               rst,
  input  wire sched_msg_pkg::ctrl_out_t     lb_head,
  input  wire                               lb_valid,
  output logic                              lb_pop,
  output sched_msg_pkg::ctrl_out_t          ctrl_out,
  output logic                              ctrl_out_valid,
  input  wire                               ctrl_out_ready
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  // counts reset words already sent, cores go in index order
  logic [core_id_width:0] rst_cnt;
  logic                   in_reset;
  ctrl_word_u             lb_word;

  assign in_reset = (rst_cnt < core_count);

  always_ff @(posedge clk) begin
    if (rst) begin
      rst_cnt <= '0;
    end else if (in_reset && ctrl_out_ready) begin
      rst_cnt <= rst_cnt + 1'b1;
    end
  end

  // type nibble zeroed so the core sends the descriptor out
  always_comb begin
    lb_word.loopback.msg_type = msg_type_e'(4'd0);
    lb_word.loopback.payload  = lb_head.data.loopback.payload;
  end

  always_comb begin
    if (in_reset) begin
      ctrl_out.data = ctrl_word_u'(core_reset_word);
      ctrl_out.dest = rst_cnt[core_id_width-1:0];
    end else begin
      ctrl_out.data = lb_word;
      ctrl_out.dest = lb_head.dest;
    end
  end

  assign ctrl_out_valid = in_reset || lb_valid;
  assign lb_pop         = !in_reset && lb_valid && ctrl_out_ready;

endmodule

`default_nettype wire

// ==== pkt_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module pkt_scheduler (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire sched_msg_pkg::rx_beat_t [sched_cfg_pkg::if_count-1:0] rx,
  input  wire  [sched_cfg_pkg::if_count-1:0]   rx_valid,
  output logic [sched_cfg_pkg::if_count-1:0]   rx_ready,
  output sched_msg_pkg::fwd_beat_t [sched_cfg_pkg::if_count-1:0] fwd,
  output logic [sched_cfg_pkg::if_count-1:0]   fwd_valid,
  input  wire  [sched_cfg_pkg::if_count-1:0]   fwd_ready,
  input  wire sched_msg_pkg::ctrl_in_t         ctrl_in,
  input  wire                                  ctrl_in_valid,
  output logic                                 ctrl_in_ready,
  output sched_msg_pkg::ctrl_out_t             ctrl_out,
  output logic                                 ctrl_out_valid,
  input  wire                                  ctrl_out_ready
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  logic [core_count-1:0]                       slot_wr;
  logic [slot_width-1:0]                       slot_wr_data;
  logic [core_count-1:0]                       slot_clear;
  logic [core_count-1:0]                       slot_room;
  logic [core_count-1:0]                       slot_pop;
  logic [core_count-1:0][fifo_depth_width-1:0] slot_counts;
  logic [core_count-1:0][slot_width-1:0]       head_slots;
  logic [core_id_width-1:0]                    best_core;
  logic                                        any_slot;

  logic      lb_wr;
  logic      lb_room;
  logic      lb_valid;
  logic      lb_pop;
  ctrl_out_t lb_data;
  ctrl_out_t lb_head;

  ctrl_ingress i_ctrl_ingress (
    .clk           (clk),
    .rst           (rst),
    .ctrl_in       (ctrl_in),
    .ctrl_in_valid (ctrl_in_valid),
    .ctrl_in_ready (ctrl_in_ready),
    .slot_wr       (slot_wr),
    .slot_wr_data  (slot_wr_data),
    .slot_clear    (slot_clear),
    .slot_room     (slot_room),
    .lb_wr         (lb_wr),
    .lb_data       (lb_data),
    .lb_room       (lb_room)
  );

  // one free slot queue per core
  for (genvar c = 0; c < core_count; c++) begin : g_slot_fifo
    slot_fifo #(
      .width (slot_width),
      .depth (slot_count)
    ) i_slot_fifo (
      .clk        (clk),
      .rst        (rst),
      .clear      (slot_clear[c]),
      .din_valid  (slot_wr[c]),
      .din        (slot_wr_data),
      .din_ready  (slot_room[c]),
      .dout_valid (),
      .dout       (head_slots[c]),
      .dout_ready (slot_pop[c]),
      .count      (slot_counts[c])
    );
  end

  slot_fifo #(
    .width (ctrl_width + core_id_width),
    .depth (loopback_depth)
  ) i_loopback_fifo (
    .clk        (clk),
    .rst        (rst),
    .clear      (1'b0),
    .din_valid  (lb_wr),
    .din        (lb_data),
    .din_ready  (lb_room),
    .dout_valid (lb_valid),
    .dout       (lb_head),
    .dout_ready (lb_pop),
    .count      ()
  );

  core_select i_core_select (
    .counts    (slot_counts),
    .best_core (best_core),
    .any_slot  (any_slot)
  );

  port_dispatch i_port_dispatch (
    .clk        (clk),
    .rst        (rst),
    .rx         (rx),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .fwd        (fwd),
    .fwd_valid  (fwd_valid),
    .fwd_ready  (fwd_ready),
    .best_core  (best_core),
    .any_slot   (any_slot),
    .head_slots (head_slots),
    .slot_pop   (slot_pop)
  );

  ctrl_egress i_ctrl_egress (
    .clk            (clk),
    .rst            (rst),
    .lb_head        (lb_head),
    .lb_valid       (lb_valid),
    .lb_pop         (lb_pop),
    .ctrl_out       (ctrl_out),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready)
  );

endmodule

`default_nettype wire

// ==== tb_pkt_scheduler.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_scheduler;
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  localparam int packets_per_port = 6;
  localparam int ctrl_timeout     = 500;
  localparam int beat_timeout     = 2000;
  localparam int drain_timeout    = 2000;

  logic                    clk;
  logic                    rst;
  rx_beat_t [if_count-1:0] rx;
  logic [if_count-1:0]     rx_valid;
  logic [if_count-1:0]     rx_ready;
  fwd_beat_t [if_count-1:0] fwd;
  logic [if_count-1:0]     fwd_valid;
  logic [if_count-1:0]     fwd_ready;
  ctrl_in_t                ctrl_in;
  logic                    ctrl_in_valid;
  logic                    ctrl_in_ready;
  ctrl_out_t               ctrl_out;
  logic                    ctrl_out_valid;
  logic                    ctrl_out_ready;

  // reference model state, updated on the rising edge
  logic [slot_width-1:0]    slot_q [core_count][$];
  logic [id_slot_width-1:0] m_dest [if_count];
  logic [if_count-1:0]      m_dest_valid;
  int                       m_rr;
  logic                     m_ld_clear;
  logic [slot_width-1:0]    m_ld_rem;
  logic [slot_width-1:0]    m_ld_next;
  logic [core_id_width-1:0] m_ld_core;
  logic [65:0]              exp_lb [$];
  rx_beat_t                 exp_beat [if_count][$];
  int                       rst_words;
  int                       ctrl_in_xfers;
  int                       rx_xfers [if_count];

  logic [31:0] rng_state = 32'h7fa1_a2a2;

  pkt_scheduler i_dut (
    .clk            (clk),
    .rst            (rst),
    .rx             (rx),
    .rx_valid       (rx_valid),
    .rx_ready       (rx_ready),
    .fwd            (fwd),
    .fwd_valid      (fwd_valid),
    .fwd_ready      (fwd_ready),
    .ctrl_in        (ctrl_in),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_out       (ctrl_out),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [63:0] load_word(input logic [2:0] n);
    return {4'h3, 57'h0, n};
  endfunction

  function automatic logic [63:0] return_word(input logic [2:0] slot, input logic [15:0] len);
    return {4'h0, 41'h0, slot, len};
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
    stop_with_failure();
  endtask

  task automatic fail_msg(input string what);
    $display("at %0t: %s", $time, what);
    stop_with_failure();
  endtask

  task automatic expect_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else fail_value(name, exp, act);
  endtask

  // only ctrl_out_valid may be high right after reset
  assert property (@(posedge clk) $fell(rst) |-> (ctrl_out_valid && fwd_valid == '0))
    else fail_msg("valid outputs are wrong in the first cycle after reset");

  // control out must hold its word until the handshake
  assert property (@(posedge clk) disable iff (rst)
    (ctrl_out_valid && !ctrl_out_ready) |=> (ctrl_out_valid && $stable(ctrl_out)))
    else fail_msg("control out word changed before it was accepted");

  // random back-pressure on both outgoing streams
  always @(negedge clk) begin : stalls
    logic [31:0] r;
    r = next_random();
    for (int p = 0; p < if_count; p++) begin
      fwd_ready[p] = (r[2*p +: 2] != 2'b00);
    end
    ctrl_out_ready = (r[9:8] != 2'b00);
  end

  always @(posedge clk) begin : model
    logic [63:0]         w;
    logic [3:0]          mt;
    logic [1:0]          src;
    logic [65:0]         lb_exp;
    rx_beat_t            beat;
    logic [if_count-1:0] xfer;
    logic [if_count-1:0] req;
    int                  best;
    int                  grant;
    int                  p;
    logic                any;
    logic                ret_push;
    logic [2:0]          ret_slot;
    logic                ld_start;
    logic [2:0]          ld_n;
    logic                ld_busy;
    if (rst) begin
      for (int c = 0; c < core_count; c++) begin
        slot_q[c].delete();
      end
      exp_lb.delete();
      m_dest_valid  = '0;
      m_rr          = 0;
      m_ld_clear    = 1'b0;
      m_ld_rem      = '0;
      rst_words     = 0;
      ctrl_in_xfers = 0;
      for (int q = 0; q < if_count; q++) begin
        rx_xfers[q] = 0;
      end
    end else begin
      w        = ctrl_in.data;
      mt       = w[63:60];
      src      = ctrl_in.user;
      ret_push = 1'b0;
      ld_start = 1'b0;
      ld_busy  = m_ld_clear || m_ld_rem != 0;
      // ready and valid checks on the state before this edge
      expect_value("ctrl_out_valid", (rst_words < core_count) || (exp_lb.size() != 0),
                   ctrl_out_valid);
      if (ctrl_in_valid && mt == 4'd0) begin
        // refused while full or while that core is being loaded
        if (slot_q[src].size() >= slot_count || (ld_busy && m_ld_core == src)) begin
          expect_value("ctrl_in_ready", 1'b0, ctrl_in_ready);
        end else if (!ld_busy) begin
          expect_value("ctrl_in_ready", 1'b1, ctrl_in_ready);
        end
      end
      if (ctrl_in_valid && mt == 4'd3) begin
        expect_value("ctrl_in_ready", !ld_busy, ctrl_in_ready);
      end
      if (ctrl_in_valid && mt == 4'd1) begin
        expect_value("ctrl_in_ready", exp_lb.size() < loopback_depth, ctrl_in_ready);
      end
      if (ctrl_in_valid && mt != 4'd0 && mt != 4'd1 && mt != 4'd3) begin
        expect_value("ctrl_in_ready", 1'b1, ctrl_in_ready);
      end
      for (int q = 0; q < if_count; q++) begin
        expect_value($sformatf("fwd_valid[%0d]", q), rx_valid[q] && m_dest_valid[q],
                     fwd_valid[q]);
        expect_value($sformatf("rx_ready[%0d]", q), fwd_ready[q] && m_dest_valid[q],
                     rx_ready[q]);
      end
      if (ctrl_out_valid && ctrl_out_ready) begin
        if (rst_words < core_count) begin
          expect_value("ctrl_out.data", {{63{1'b1}}, 1'b0}, ctrl_out.data);
          expect_value("ctrl_out.dest", rst_words, ctrl_out.dest);
          rst_words++;
        end else begin
          lb_exp = exp_lb.pop_front();
          expect_value("ctrl_out.data", lb_exp[65:2], ctrl_out.data);
          expect_value("ctrl_out.dest", lb_exp[1:0], ctrl_out.dest);
        end
      end
      if (ctrl_in_valid && ctrl_in_ready) begin
        ctrl_in_xfers++;
        case (mt)
          4'd0: begin
            ret_push = 1'b1;
            ret_slot = w[18:16];
          end
          4'd1: exp_lb.push_back({4'h0, w[59:0], src});
          4'd3: begin
            ld_start = 1'b1;
            ld_n     = (w[2:0] > 3'(slot_count)) ? 3'(slot_count) : w[2:0];
          end
          default: ;
        endcase
      end
      for (int q = 0; q < if_count; q++) begin
        xfer[q] = rx_valid[q] && fwd_ready[q] && m_dest_valid[q];
        req[q]  = !m_dest_valid[q] || (xfer[q] && rx[q].last);
        if (xfer[q]) begin
          if (exp_beat[q].size() == 0) begin
            fail_msg($sformatf("port %0d forwarded a beat that was never sent", q));
          end
          beat = exp_beat[q].pop_front();
          expect_value($sformatf("fwd[%0d].data", q), beat.data, fwd[q].data);
          expect_value($sformatf("fwd[%0d].keep", q), beat.keep, fwd[q].keep);
          expect_value($sformatf("fwd[%0d].last", q), beat.last, fwd[q].last);
          expect_value($sformatf("fwd[%0d].user", q), q, fwd[q].user);
          expect_value($sformatf("fwd[%0d].dest", q), m_dest[q], fwd[q].dest);
          rx_xfers[q]++;
        end
      end
      // scheduling rule: most free slots, lowest core on a tie
      best = 0;
      any  = 1'b0;
      for (int c = 0; c < core_count; c++) begin
        if (slot_q[c].size() > slot_q[best].size()) begin
          best = c;
        end
        if (slot_q[c].size() != 0) begin
          any = 1'b1;
        end
      end
      grant = -1;
      for (int k = 0; k < if_count; k++) begin
        p = (m_rr + k) % if_count;
        if (grant < 0 && any && req[p]) begin
          grant = p;
        end
      end
      for (int q = 0; q < if_count; q++) begin
        if (xfer[q] && rx[q].last) begin
          m_dest_valid[q] = 1'b0;
        end
      end
      if (grant >= 0) begin
        m_dest_valid[grant] = 1'b1;
        m_dest[grant]       = {core_id_width'(best), slot_q[best].pop_front()};
        m_rr                = (grant + 1) % if_count;
      end
      // loader clears first, then writes slots 1..n
      if (m_ld_clear) begin
        slot_q[m_ld_core].delete();
        m_ld_clear = 1'b0;
      end else if (m_ld_rem != 0) begin
        slot_q[m_ld_core].push_back(m_ld_next);
        m_ld_next = m_ld_next + 1'b1;
        m_ld_rem  = m_ld_rem - 1'b1;
      end
      if (ret_push) begin
        slot_q[src].push_back(ret_slot);
      end
      if (ld_start) begin
        m_ld_clear = 1'b1;
        m_ld_rem   = ld_n;
        m_ld_next  = 3'd1;
        m_ld_core  = src;
      end
    end
  end

  task automatic send_ctrl(input logic [1:0] core, input logic [63:0] word);
    int start;
    int waited;
    @(negedge clk);
    ctrl_in.data  = ctrl_word_u'(word);
    ctrl_in.user  = core;
    ctrl_in_valid = 1'b1;
    start  = ctrl_in_xfers;
    waited = 0;
    while (ctrl_in_xfers == start) begin
      @(negedge clk);
      waited++;
      if (waited > ctrl_timeout) begin
        fail_msg("timeout waiting for a control input handshake");
      end
    end
    ctrl_in_valid = 1'b0;
  endtask

  task automatic send_packet(input int p, input int len);
    rx_beat_t    b;
    logic [31:0] r;
    int          start;
    int          waited;
    @(negedge clk);
    for (int i = 0; i < len; i++) begin
      r      = next_random();
      b.data = {next_random(), r};
      b.last = (i == len - 1);
      b.keep = b.last ? {r[7:1], 1'b1} : 8'hff;
      rx[p]       = b;
      rx_valid[p] = 1'b1;
      exp_beat[p].push_back(b);
      start  = rx_xfers[p];
      waited = 0;
      while (rx_xfers[p] == start) begin
        @(negedge clk);
        waited++;
        if (waited > beat_timeout) begin
          fail_msg($sformatf("timeout waiting for port %0d to take a beat", p));
        end
      end
    end
    rx_valid[p] = 1'b0;
  endtask

  task automatic send_stream(input int p);
    int len;
    for (int i = 0; i < packets_per_port; i++) begin
      repeat (next_random() % 4) @(negedge clk);
      len = 1 + int'(next_random() % 4);
      send_packet(p, len);
    end
  endtask

  // frees slots to the emptiest core, with one reload halfway
  task automatic return_slots(input int n);
    int          target;
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      repeat (4 + (next_random() % 12)) @(negedge clk);
      target = 0;
      for (int c = 1; c < core_count; c++) begin
        if (slot_q[c].size() < slot_q[target].size()) begin
          target = c;
        end
      end
      r = next_random();
      send_ctrl(2'(target), return_word(3'((i % slot_count) + 1), r[15:0]));
      if (i == n / 2) begin
        send_ctrl(2'd0, load_word(3'(slot_count)));
      end
    end
  endtask

  task automatic wait_reset_words();
    int waited;
    waited = 0;
    while (rst_words < core_count) begin
      @(negedge clk);
      waited++;
      if (waited > ctrl_timeout) begin
        fail_msg("timeout waiting for the core reset words");
      end
    end
  endtask

  task automatic wait_loader_idle();
    int waited;
    waited = 0;
    while (m_ld_clear || m_ld_rem != 0) begin
      @(negedge clk);
      waited++;
      if (waited > ctrl_timeout) begin
        fail_msg("timeout waiting for the slot loader to finish");
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_lb.size() != 0 || exp_beat[0].size() != 0 || exp_beat[1].size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > drain_timeout) begin
        fail_msg("timeout waiting for pending beats and loopback words to drain");
      end
    end
  endtask

  initial begin : stimulus
    rst            = 1'b1;
    rx             = '0;
    rx_valid       = '0;
    fwd_ready      = '0;
    ctrl_in        = '0;
    ctrl_in_valid  = 1'b0;
    ctrl_out_ready = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait_reset_words();
    // uneven loads so the selection order matters
    send_ctrl(2'd0, load_word(3'd2));
    wait_loader_idle();
    send_ctrl(2'd1, load_word(3'd4));
    send_ctrl(2'd2, load_word(3'd3));
    send_ctrl(2'd3, load_word(3'd1));
    wait_loader_idle();
    for (int i = 0; i < 3; i++) begin
      send_ctrl(2'(i + 1), {4'h1, 28'(next_random()), next_random()});
    end
    // unknown type, swallowed without effect
    send_ctrl(2'd2, {4'h5, 60'h0_1234_5678_9abc});
    fork
      send_stream(0);
      send_stream(1);
      return_slots(8);
    join
    wait_drain();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
sched_cfg_pkg.sv
sched_msg_pkg.sv
slot_fifo.sv
ctrl_ingress.sv
core_select.sv
port_dispatch.sv
ctrl_egress.sv
pkt_scheduler.sv
tb_pkt_scheduler.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pkt_scheduler \
  -f flist.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log \
  && grep -qx "TEST OK" sim.log \
  || { echo "simulation did not pass"; exit 1; }
